/* hw/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths and sizes of the data-memory subsystem
////////////////////////////////////////////////////////////////////////////

// Byte address
`define ADDR_W 32

// Bus and register data
`define DATA_W 32

// Memory depth in words
`define MEM_WORDS 256

// Register file address
`define REG_AW 5

`endif

/* hw/bus_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

////////////////////////////////////////////////////////////////////////////
// Memory bus types
////////////////////////////////////////////////////////////////////////////

package bus_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [3:0]         strb_t; // All zero is a read

  typedef enum logic [1:0] {
    arb_idle       = 2'd0,
    arb_data_busy  = 2'd1,
    arb_fetch_busy = 2'd2
  } arb_state_t;

endpackage

`default_nettype wire

/* hw/pipe_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

////////////////////////////////////////////////////////////////////////////
// Pipeline-side types
////////////////////////////////////////////////////////////////////////////

package pipe_pkg;

  // Destination register
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // Access size of a load or store
  typedef enum logic [1:0] {
    ls_byte = 2'd0,
    ls_half = 2'd1,
    ls_word = 2'd2
  } ls_width_t;

  // Memory stage sequencing
  typedef enum logic [1:0] {
    ms_ready     = 2'd0, // Free to take an instruction
    ms_wait_bus  = 2'd1, // Bus access outstanding
    ms_writeback = 2'd2  // Result presented
  } mem_state_t;

endpackage

`default_nettype wire

/* hw/mem_bus_if.sv */
`default_nettype none

// One request/ready memory port
interface mem_bus_if;
  import bus_pkg::*;

  logic  req;   // Held until ready
  addr_t addr;
  data_t wdata;
  strb_t strb;
  data_t rdata;
  logic  ready; // One-cycle pulse

  modport master (
    output req, addr, wdata, strb,
    input  rdata, ready
  );

  modport slave (
    input  req, addr, wdata, strb,
    output rdata, ready
  );

endinterface

`default_nettype wire

/* hw/memory_stage.sv */
`default_nettype none

module memory_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                ex_valid,
  input  logic                ex_load,
  input  logic                ex_store,
  input  logic                ex_unsigned,
  input  pipe_pkg::ls_width_t ex_width,
  input  bus_pkg::addr_t      ex_addr,
  input  bus_pkg::data_t      ex_sdata,
  input  pipe_pkg::reg_addr_t ex_waddr,
  input  logic                clear,
  mem_bus_if.master           bus,
  output logic                stall,
  output logic                wb_valid,
  output logic                wb_wren,
  output logic                wb_exception,
  output pipe_pkg::reg_addr_t wb_waddr,
  output bus_pkg::data_t      wb_wdata
);
  import pipe_pkg::*;
  import bus_pkg::*;

  mem_state_t state;

  // Access latched at take
  logic      acc_load;
  logic      acc_store;
  logic      acc_unsigned;
  ls_width_t acc_width;
  addr_t     acc_addr;
  data_t     acc_sdata;

  logic  killed; // Write-back dropped by clear
  logic  wren_q;
  logic  exc_q;

  logic  take;
  logic  addr_bad;
  logic  misaligned;
  strb_t lane_strb;
  data_t shifted;
  logic  sign_bit;
  data_t load_data;

  assign stall = (state == ms_wait_bus);
  assign take  = ex_valid & ~stall;

  always_comb begin
    case (ex_width)
      ls_half: addr_bad = ex_addr[0];
      ls_word: addr_bad = |ex_addr[1:0];
      default: addr_bad = 1'b0;
    endcase
  end

  assign misaligned = addr_bad & (ex_load | ex_store);

  ////////////////////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (acc_width)
      ls_byte: begin
        bus.wdata = {4{acc_sdata[7:0]}};
        lane_strb = strb_t'(4'b0001 << acc_addr[1:0]);
      end
      ls_half: begin
        bus.wdata = {2{acc_sdata[15:0]}};
        lane_strb = acc_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        bus.wdata = acc_sdata;
        lane_strb = 4'b1111;
      end
    endcase
  end

  assign bus.req  = stall;
  assign bus.addr = acc_addr;
  assign bus.strb = acc_store ? lane_strb : '0; // Loads read

  // Load alignment and extension
  assign shifted = bus.rdata >> {acc_addr[1:0], 3'b000};

  always_comb begin
    case (acc_width)
      ls_byte: begin
        sign_bit  = ~acc_unsigned & shifted[7];
        load_data = {{($bits(data_t)-8){sign_bit}}, shifted[7:0]};
      end
      ls_half: begin
        sign_bit  = ~acc_unsigned & shifted[15];
        load_data = {{($bits(data_t)-16){sign_bit}}, shifted[15:0]};
      end
      default: begin
        sign_bit  = 1'b0;
        load_data = shifted;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state  <= ms_ready;
      killed <= 1'b0;
      wren_q <= 1'b0;
      exc_q  <= 1'b0;
    end else begin
      case (state)
        ms_ready, ms_writeback: begin
          if (take) begin
            killed <= clear;
            exc_q  <= misaligned;
            wren_q <= ex_load & ~misaligned; // Only loads write back
            if ((ex_load | ex_store) && !misaligned) begin
              state <= ms_wait_bus;
            end else begin
              state <= ms_writeback;
            end
          end else begin
            state <= ms_ready;
          end
        end
        ms_wait_bus: begin
          killed <= killed | clear; // Access still completes
          if (bus.ready) begin
            state <= ms_writeback;
          end
        end
        default: state <= ms_ready;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      acc_load     <= ex_load;
      acc_store    <= ex_store & ~misaligned;
      acc_unsigned <= ex_unsigned;
      acc_width    <= ex_width;
      acc_addr     <= ex_addr;
      acc_sdata    <= ex_sdata;
      wb_waddr     <= ex_waddr;
      wb_wdata     <= '0;
    end else if (stall && bus.ready && acc_load) begin
      wb_wdata <= load_data;
    end
  end

  assign wb_valid     = (state == ms_writeback) & ~killed & ~clear;
  assign wb_wren      = wb_valid & wren_q;
  assign wb_exception = wb_valid & exc_q;

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

module fetch_unit (
  input  logic           clock,
  input  logic           reset,
  input  logic           fetch_en,
  input  logic           redirect,
  input  bus_pkg::addr_t redirect_pc,
  mem_bus_if.master      bus,
  output logic           instr_valid,
  output bus_pkg::data_t instr,
  output bus_pkg::addr_t instr_pc
);
  import bus_pkg::*;

  addr_t pc_q;       // Next address to fetch
  addr_t req_addr_q; // Address of the read on the bus
  logic  req_q;
  logic  stale_q;    // Read overtaken by a redirect
  logic  issue;

  // New read when the port is free or its read completes now
  assign issue = fetch_en & ~redirect & (~req_q | bus.ready);

  assign bus.req   = req_q;
  assign bus.addr  = req_addr_q;
  assign bus.wdata = '0;
  assign bus.strb  = '0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q        <= '0;
      req_q       <= 1'b0;
      stale_q     <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= bus.ready & ~stale_q & ~redirect;

      if (bus.ready) begin
        stale_q <= 1'b0;
      end else if (redirect && req_q) begin
        stale_q <= 1'b1;
      end

      if (issue) begin
        req_q <= 1'b1;
      end else if (bus.ready) begin
        req_q <= 1'b0;
      end

      if (redirect) begin
        pc_q <= redirect_pc;
      end else if (issue) begin
        pc_q <= pc_q + addr_t'(4);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      req_addr_q <= pc_q;
    end
    if (bus.ready) begin
      instr    <= bus.rdata;
      instr_pc <= req_addr_q;
    end
  end

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
  input  logic     clock,
  input  logic     reset,
  mem_bus_if.slave data_port,
  mem_bus_if.slave fetch_port,
  mem_bus_if.master mem
);
  import bus_pkg::*;

  arb_state_t state;
  logic       data_grant;
  logic       fetch_grant;

  assign data_grant  = (state == arb_data_busy);
  assign fetch_grant = (state == arb_fetch_busy);

  ////////////////////////////////////////////////////////////////////////////
  // Grant FSM, data port has priority
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= arb_idle;
    end else begin
      case (state)
        arb_idle: begin
          if (data_port.req) begin
            state <= arb_data_busy;
          end else if (fetch_port.req) begin
            state <= arb_fetch_busy;
          end
        end
        arb_data_busy, arb_fetch_busy: begin
          if (mem.ready) begin
            state <= arb_idle; // Back through idle on every change
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  // Request path
  always_comb begin
    if (fetch_grant) begin
      mem.req   = fetch_port.req;
      mem.addr  = fetch_port.addr;
      mem.wdata = fetch_port.wdata;
      mem.strb  = fetch_port.strb;
    end else begin
      mem.req   = data_grant & data_port.req;
      mem.addr  = data_port.addr;
      mem.wdata = data_port.wdata;
      mem.strb  = data_port.strb;
    end
  end

  // Response only to the granted master
  assign data_port.ready  = data_grant & mem.ready;
  assign data_port.rdata  = data_grant ? mem.rdata : '0;
  assign fetch_port.ready = fetch_grant & mem.ready;
  assign fetch_port.rdata = fetch_grant ? mem.rdata : '0;

endmodule

`default_nettype wire

/* hw/data_ram.sv */
`default_nettype none

`include "mem_consts.svh"

module data_ram (
  input  logic     clock,
  input  logic     reset,
  mem_bus_if.slave bus
);
  import bus_pkg::*;

  localparam int unsigned idx_w = $clog2(`MEM_WORDS);

  data_t             mem [`MEM_WORDS];
  logic [idx_w-1:0]  idx;
  logic              ready_q;
  logic              access;
  data_t             rdata_q;

  assign idx    = bus.addr[idx_w+1:2]; // Word index
  assign access = bus.req & ~ready_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  // Write lands on the edge that raises ready
  always_ff @(posedge clock) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.strb[i]) begin
          mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* hw/mem_subsys_top.sv */
`default_nettype none

module mem_subsys_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                ex_valid,
  input  logic                ex_load,
  input  logic                ex_store,
  input  logic                ex_unsigned,
  input  pipe_pkg::ls_width_t ex_width,
  input  bus_pkg::addr_t      ex_addr,
  input  bus_pkg::data_t      ex_sdata,
  input  pipe_pkg::reg_addr_t ex_waddr,
  input  logic                clear,
  input  logic                fetch_en,
  input  logic                redirect,
  input  bus_pkg::addr_t      redirect_pc,
  output logic                stall,
  output logic                wb_valid,
  output logic                wb_wren,
  output logic                wb_exception,
  output pipe_pkg::reg_addr_t wb_waddr,
  output bus_pkg::data_t      wb_wdata,
  output logic                instr_valid,
  output bus_pkg::data_t      instr,
  output bus_pkg::addr_t      instr_pc
);

  mem_bus_if data_bus ();
  mem_bus_if fetch_bus ();
  mem_bus_if ram_bus ();

  memory_stage stage0 (
    .clock        (clock),
    .reset        (reset),
    .ex_valid     (ex_valid),
    .ex_load      (ex_load),
    .ex_store     (ex_store),
    .ex_unsigned  (ex_unsigned),
    .ex_width     (ex_width),
    .ex_addr      (ex_addr),
    .ex_sdata     (ex_sdata),
    .ex_waddr     (ex_waddr),
    .clear        (clear),
    .bus          (data_bus.master),
    .stall        (stall),
    .wb_valid     (wb_valid),
    .wb_wren      (wb_wren),
    .wb_exception (wb_exception),
    .wb_waddr     (wb_waddr),
    .wb_wdata     (wb_wdata)
  );

  fetch_unit fetch0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_en    (fetch_en),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .bus         (fetch_bus.master),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc)
  );

  // Shared word memory
  bus_arbiter arb0 (
    .clock      (clock),
    .reset      (reset),
    .data_port  (data_bus.slave),
    .fetch_port (fetch_bus.slave),
    .mem        (ram_bus.master)
  );

  data_ram ram0 (
    .clock (clock),
    .reset (reset),
    .bus   (ram_bus.slave)
  );

endmodule

`default_nettype wire

/* sim/mem_subsys_assertions.sv */
`default_nettype none

module mem_subsys_assertions (
  input logic        clock,
  input logic        reset,
  input logic        data_req,
  input logic        data_ready,
  input logic [31:0] data_addr,
  input logic        fetch_req,
  input logic        fetch_ready,
  input logic [31:0] fetch_addr,
  input logic        mem_req,
  input logic        mem_ready,
  input logic        data_grant,
  input logic        fetch_grant,
  input logic        stall,
  input logic        wb_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////////////////////////////////////////

  data_req_held: assert property (@(posedge clock) disable iff (!reset)
    data_req && !data_ready |=> data_req && $stable(data_addr))
    else $error("data request dropped or changed before ready");

  fetch_req_held: assert property (@(posedge clock) disable iff (!reset)
    fetch_req && !fetch_ready |=> fetch_req && $stable(fetch_addr))
    else $error("fetch request dropped or changed before ready");

  ready_after_req: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |-> $past(mem_req))
    else $error("memory ready without a request");

  one_grant: assert property (@(posedge clock) disable iff (!reset)
    !(data_grant && fetch_grant))
    else $error("both ports granted");

  // Write-back never cuts a stall short of the data ready
  stall_vs_wb: assert property (@(posedge clock) disable iff (!reset)
    wb_valid |-> !$past(stall) || $past(data_ready))
    else $error("write-back ended a stall without a data ready");

endmodule

`default_nettype wire

/* sim/mem_subsys_tb.sv */
`default_nettype none

`include "mem_consts.svh"

module mem_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import pipe_pkg::*;
  import bus_pkg::*;

  localparam int fetch_start = 9; // First line run with fetch enabled
  localparam logic [31:0] redirect_target = 32'h0000_0008;

  logic clock = 1'b0;
  logic reset;
  logic ex_valid, ex_load, ex_store, ex_unsigned, clear;
  ls_width_t ex_width;
  addr_t ex_addr;
  data_t ex_sdata;
  reg_addr_t ex_waddr;
  logic fetch_en, redirect;
  addr_t redirect_pc;
  logic stall, wb_valid, wb_wren, wb_exception;
  reg_addr_t wb_waddr;
  data_t wb_wdata;
  logic instr_valid;
  data_t instr;
  addr_t instr_pc;

  // Stimulus lines
  int q_num[$];
  bit q_load[$];
  int q_width[$];
  bit q_uns[$];
  logic [31:0] q_addr[$];
  logic [31:0] q_sdata[$];
  int q_rd[$];
  bit q_clear[$];
  bit q_exc[$];
  logic [31:0] q_exp[$];

  // Expected memory image, byte-wise known flags
  logic [31:0] shadow [`MEM_WORDS];
  logic [3:0] known [`MEM_WORDS];

  int errors = 0;
  int checks = 0;
  int cur_test = 0;
  int cycles = 0;
  int limit = 0;
  int fetch_count = 0;
  int redirects = 0;
  logic [31:0] expect_pc = 32'h0;
  logic redirect_pending = 1'b0;

  mem_subsys_top dut0 (.*);

  bind bus_arbiter mem_subsys_assertions asrt0 (
    .clock       (clock),
    .reset       (reset),
    .data_req    (data_port.req),
    .data_ready  (data_port.ready),
    .data_addr   (data_port.addr),
    .fetch_req   (fetch_port.req),
    .fetch_ready (fetch_port.ready),
    .fetch_addr  (fetch_port.addr),
    .mem_req     (mem.req),
    .mem_ready   (mem.ready),
    .data_grant  (data_grant),
    .fetch_grant (fetch_grant),
    .stall       (stage0.stall),
    .wb_valid    (stage0.wb_valid)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("run stopped after %0d cycles without finishing", limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL test %0d %s got %h expected %h", cur_test, name, got, exp);
      errors++;
    end
  endtask

  task automatic apply_store(input logic [31:0] addr, input int width,
                             input logic [31:0] data);
    int idx;
    int lane;
    idx = int'(addr[9:2]);
    lane = int'(addr[1:0]);
    for (int b = 0; b < width; b++) begin
      shadow[idx][8*(lane+b) +: 8] = data[8*b +: 8];
      known[idx][lane+b] = 1'b1;
    end
  endtask

  task automatic read_stim();
    int fd;
    int n;
    string line;
    string op;
    int num, width, uns, rd, clr, exc;
    logic [31:0] addr, sdata, exp;
    fd = $fopen("sim/mem_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("test failed");
      $finish;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 3 || line.substr(0, 0) == "#") continue;
        n = $sscanf(line, "%d %s %d %d %h %h %d %d %d %h",
                    num, op, width, uns, addr, sdata, rd, clr, exc, exp);
        if (n != 10) continue;
        q_num.push_back(num);
        q_load.push_back(op == "L");
        q_width.push_back(width);
        q_uns.push_back(uns != 0);
        q_addr.push_back(addr);
        q_sdata.push_back(sdata);
        q_rd.push_back(rd);
        q_clear.push_back(clr != 0);
        q_exc.push_back(exc != 0);
        q_exp.push_back(exp);
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction fetch monitor and redirect
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (reset === 1'b1 && instr_valid === 1'b1) begin
      fetch_count++;
      check_val("instr_pc", instr_pc, expect_pc);
      if (known[instr_pc[9:2]] == 4'hf) begin
        check_val("instr", instr, shadow[instr_pc[9:2]]);
      end else begin
        $display("instruction fetched from unwritten address %h", instr_pc);
        errors++;
      end
      if (instr_pc == 32'h1c) begin
        redirect_pending = 1'b1; // Loop back over the written words
        expect_pc = redirect_target;
        redirects++;
      end else begin
        expect_pc = instr_pc + 32'd4;
      end
    end
  end

  always @(posedge clock) begin
    #2;
    redirect = redirect_pending;
    redirect_pending = 1'b0;
  end

  initial begin
    int err_before;
    bit saw_stall;
    bit done;
    reset = 1'b0;
    ex_valid = 1'b0;
    ex_load = 1'b0;
    ex_store = 1'b0;
    ex_unsigned = 1'b0;
    ex_width = ls_word;
    ex_addr = '0;
    ex_sdata = '0;
    ex_waddr = '0;
    clear = 1'b0;
    fetch_en = 1'b0;
    redirect = 1'b0;
    redirect_pc = redirect_target;
    for (int i = 0; i < `MEM_WORDS; i++) known[i] = 4'h0;
    read_stim();
    limit = 40 * q_num.size() + 500;

    repeat (10) @(posedge clock);
    #2 reset = 1'b1;

    for (int i = 0; i < q_num.size(); i++) begin
      @(posedge clock);
      #2;
      cur_test = q_num[i];
      err_before = errors;
      if (cur_test >= fetch_start) fetch_en = 1'b1;
      ex_valid = 1'b1;
      ex_load = q_load[i];
      ex_store = !q_load[i];
      ex_unsigned = q_uns[i];
      ex_width = (q_width[i] == 1) ? ls_byte : (q_width[i] == 2) ? ls_half : ls_word;
      ex_addr = q_addr[i];
      ex_sdata = q_sdata[i];
      ex_waddr = reg_addr_t'(q_rd[i]);
      clear = q_clear[i];
      @(posedge clock); // Taken here, stall is low
      #2;
      ex_valid = 1'b0;
      clear = 1'b0;
      saw_stall = 1'b0;
      done = 1'b0;
      while (!done) begin
        @(negedge clock);
        if (stall) saw_stall = 1'b1;
        if (q_clear[i]) begin
          assert (!wb_valid) else begin
            $display("write-back seen for a cleared access in test %0d", cur_test);
            errors++;
          end
          if (saw_stall && !stall) done = 1'b1;
        end else if (wb_valid) begin
          done = 1'b1;
          // Only a legal access waits on the bus
          check_val("stall", 32'(saw_stall), 32'(!q_exc[i]));
          check_val("wb_exception", 32'(wb_exception), 32'(q_exc[i]));
          check_val("wb_waddr", 32'(wb_waddr), 32'(q_rd[i]));
          if (q_load[i] && !q_exc[i]) begin
            check_val("wb_wren", 32'(wb_wren), 32'd1);
            check_val("wb_wdata", wb_wdata, q_exp[i]);
          end else begin
            check_val("wb_wren", 32'(wb_wren), 32'd0);
          end
          if (!q_load[i] && !q_exc[i]) apply_store(q_addr[i], q_width[i], q_sdata[i]);
        end
      end
      $display("test %2d finished with %0d errors", cur_test, errors - err_before);
    end

    fetch_en = 1'b0;
    repeat (20) @(posedge clock);
    assert (fetch_count >= 8 && redirects >= 1) else begin
      $display("fetch port delivered too few instructions or never looped");
      errors++;
    end
    $display("%0d tests, %0d checks, %0d fetched, %0d errors",
             q_num.size(), checks, fetch_count, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/mem_stim.txt */
# test op width(bytes) unsigned addr store_data rd clear exp_exception exp_load_data
# op is L or S, hex for addr and data, decimal for the rest
1 S 4 0 00000000 13579bdf 0 0 0 00000000
2 S 4 0 00000004 2468ace0 0 0 0 00000000
3 S 4 0 00000008 0badf00d 0 0 0 00000000
4 S 4 0 0000000c cafebabe 0 0 0 00000000
5 S 4 0 00000010 00112233 0 0 0 00000000
6 S 4 0 00000014 44556677 0 0 0 00000000
7 S 4 0 00000018 8899aabb 0 0 0 00000000
8 S 4 0 0000001c ccddeeff 0 0 0 00000000
9 L 4 0 00000000 00000000 5 0 0 13579bdf
10 L 4 0 0000001c 00000000 6 0 0 ccddeeff
11 S 4 0 00000040 00000000 0 0 0 00000000
12 S 1 0 00000041 00000085 0 0 0 00000000
13 S 2 0 00000042 0000f00d 0 0 0 00000000
14 S 1 0 00000040 0000007f 0 0 0 00000000
15 L 4 0 00000040 00000000 7 0 0 f00d857f
16 L 1 0 00000041 00000000 8 0 0 ffffff85
17 L 1 1 00000041 00000000 8 0 0 00000085
18 L 2 0 00000042 00000000 8 0 0 fffff00d
19 L 2 1 00000042 00000000 8 0 0 0000f00d
20 L 1 0 00000040 00000000 8 0 0 0000007f
21 L 2 0 00000040 00000000 8 0 0 ffff857f
22 S 4 0 00000042 deadbeef 0 0 1 00000000
23 S 2 0 00000041 0000beef 0 0 1 00000000
24 L 4 0 00000043 00000000 9 0 1 00000000
25 L 4 0 00000040 00000000 10 0 0 f00d857f
26 L 4 0 00000004 00000000 11 1 0 00000000
27 L 4 0 00000004 00000000 12 0 0 2468ace0
28 L 2 1 0000000e 00000000 13 0 0 0000cafe
29 L 1 0 0000000b 00000000 14 0 0 0000000b
30 L 1 0 0000001f 00000000 15 0 0 ffffffcc

/* all.f */
+incdir+hw
hw/bus_pkg.sv
hw/pipe_pkg.sv
hw/mem_bus_if.sv
hw/memory_stage.sv
hw/fetch_unit.sv
hw/bus_arbiter.sv
hw/data_ram.sv
hw/mem_subsys_top.sv
sim/mem_subsys_assertions.sv
sim/mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run from the project root
verilator --binary --timing --assert -f all.f --top-module mem_subsys_tb \
  -o mem_subsys_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
